// ==== hw/dcp_consts.svh ====
`ifndef DCP_CONSTS_SVH
`define DCP_CONSTS_SVH

// command codes
`define DCP_CMD_D           8'h44

// dump line geometry
`define DCP_WORDS_PER_DUMP  8
`define DCP_HEX_DIGITS      8

// data memory size
`define DCP_MEM_DEPTH       256
`define DCP_MEM_AW          8

// console characters
`define DCP_CHAR_DASH       8'h2D
`define DCP_CHAR_COLON      8'h3A
`define DCP_CHAR_CR         8'h0D
`define DCP_CHAR_LF         8'h0A

`endif

// ==== hw/dcp_pkg.sv ====
`include "dcp_consts.svh"

package dcp_pkg;

    typedef logic [7:0]             byte_t;
    typedef logic [31:0]            word_t;
    typedef logic [`DCP_MEM_AW-1:0] mem_addr_t;

    // 0 prints the low byte as a character, 1 prints a word as hex digits
    typedef logic                   print_kind_t;

    typedef enum logic [2:0] {
        INIT,
        SCAN,
        PRINT_HDR,
        PRINT_ADDR,
        PRINT_COLON,
        FETCH,
        PRINT_DATA,
        FINISH
    } dump_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_COLLECT,
        RX_ACK
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_ACK,
        TX_RELEASE
    } tx_state_t;

endpackage

// ==== hw/dcp_link_if.sv ====
`timescale 1ns/1ps

// level request, one-cycle acknowledge
interface dcp_link_if
    import dcp_pkg::*;
();
    logic        req;
    print_kind_t kind;
    word_t       wdata;
    word_t       rdata;
    logic        empty;
    logic        ack;

    // the dump sequencer side
    modport requester (
        output req,
        output kind,
        output wdata,
        input  rdata,
        input  empty,
        input  ack
    );

    // scanner and printer side
    modport server (
        input  req,
        input  kind,
        input  wdata,
        output rdata,
        output empty,
        output ack
    );
endinterface

// ==== hw/dcp_cmd_decode.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module dcp_cmd_decode
    import dcp_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  rx_valid,
    input  byte_t rx_byte,
    input  logic  finish,
    output byte_t sel_mode
);
    logic idle;
    logic is_cmd;

    // a new command is only taken while nothing runs
    assign idle = (sel_mode == 8'h00);

    // only D is known so far
    assign is_cmd = (rx_byte == `DCP_CMD_D);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sel_mode <= '0;
        end else if (finish) begin
            // command done, back to listening
            sel_mode <= '0;
        end else if (idle && rx_valid && is_cmd) begin
            sel_mode <= rx_byte;
        end
    end

endmodule

// ==== hw/dcp_rx_scanner.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module dcp_rx_scanner
    import dcp_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       rx_valid,
    input  byte_t      rx_byte,
    dcp_link_if.server link
);
    rx_state_t  state;
    word_t      acc;
    logic       got_digit;
    logic       ack_q;
    logic       take;
    logic       is_hex;
    logic [3:0] hex_nib;

    // ascii hex digit, either case
    always_comb begin
        is_hex  = 1'b1;
        hex_nib = 4'h0;
        if (rx_byte >= 8'h30 && rx_byte <= 8'h39) begin
            hex_nib = rx_byte[3:0];
        end else if ((rx_byte >= 8'h41 && rx_byte <= 8'h46) ||
                     (rx_byte >= 8'h61 && rx_byte <= 8'h66)) begin
            hex_nib = rx_byte[3:0] + 4'd9;
        end else begin
            is_hex = 1'b0;
        end
    end

    // bytes only count while a request is open
    assign take = rx_valid && link.req && (state == RX_COLLECT);

    assign link.rdata = acc;
    assign link.empty = !got_digit;
    assign link.ack   = ack_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= RX_IDLE;
            got_digit <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (link.req) begin
                        got_digit <= 1'b0;
                        state     <= RX_COLLECT;
                    end
                end
                RX_COLLECT: begin
                    if (take && rx_byte == `DCP_CHAR_CR) begin
                        ack_q <= 1'b1;
                        state <= RX_ACK;
                    end else if (take && is_hex) begin
                        got_digit <= 1'b1;
                    end
                end
                RX_ACK: begin
                    // hold off until the requester lets go
                    if (!link.req) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // shift in digits, older ones fall off the top
    always_ff @(posedge clk) begin
        if (state == RX_IDLE) begin
            acc <= '0;
        end else if (take && is_hex) begin
            acc <= {acc[27:0], hex_nib};
        end
    end

endmodule

// ==== hw/dcp_tx_printer.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module dcp_tx_printer
    import dcp_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    dcp_link_if.server link,
    input  logic       tx_ready,
    output logic       tx_valid,
    output byte_t      tx_byte
);
    localparam int            NW       = $clog2(`DCP_HEX_DIGITS);
    localparam logic [NW-1:0] LAST_NIB = NW'(`DCP_HEX_DIGITS - 1);

    tx_state_t     state;
    print_kind_t   kind_q;
    word_t         data_q;
    logic [NW-1:0] nib_cnt;
    logic [3:0]    nibble;
    logic          last;

    // upper-case hex digit for one nibble
    function automatic byte_t hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h37 + {4'h0, n};
    endfunction

    // most significant nibble goes out first
    assign nibble = data_q[4 * (LAST_NIB - nib_cnt) +: 4];
    assign last   = (kind_q == 1'b0) || (nib_cnt == LAST_NIB);

    assign tx_valid = (state == TX_SEND) && tx_ready;
    assign tx_byte  = kind_q ? hex_char(nibble) : data_q[7:0];

    assign link.ack   = (state == TX_ACK);
    assign link.rdata = data_q;
    assign link.empty = 1'b0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= TX_IDLE;
            nib_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (link.req) begin
                        nib_cnt <= '0;
                        state   <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    // stall while the console is not ready
                    if (tx_ready) begin
                        if (last) begin
                            state <= TX_ACK;
                        end else begin
                            nib_cnt <= nib_cnt + 1'b1;
                        end
                    end
                end
                TX_ACK: begin
                    state <= TX_RELEASE;
                end
                TX_RELEASE: begin
                    if (!link.req) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // job operands latched once at start
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && link.req) begin
            kind_q <= link.kind;
            data_q <= link.wdata;
        end
    end

endmodule

// ==== hw/dcp_dump.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module dcp_dump
    import dcp_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  byte_t         sel_mode,
    dcp_link_if.requester rx_link,
    dcp_link_if.requester tx_link,
    output mem_addr_t     mem_addr,
    input  word_t         mem_rdata,
    output logic          finish
);
    localparam int             WCW       = $clog2(`DCP_WORDS_PER_DUMP);
    localparam logic [WCW-1:0] LAST_WORD = WCW'(`DCP_WORDS_PER_DUMP - 1);

    dump_state_t    state;
    logic           rx_req;
    logic           tx_req;
    logic           hdr_cnt;
    logic           trl_cnt;
    logic [WCW-1:0] word_cnt;
    word_t          cur_addr;
    word_t          last_addr;
    logic           start;

    // sel_mode is still set in the finish cycle, so mask it
    assign start = (sel_mode == `DCP_CMD_D) && !finish;

    assign rx_link.req   = rx_req;
    assign rx_link.kind  = 1'b1;
    assign rx_link.wdata = last_addr;
    assign tx_link.req   = tx_req;

    // reads wrap on the low address bits
    assign mem_addr = cur_addr[`DCP_MEM_AW-1:0];

    // what to print, held steady for the whole request
    always_comb begin
        tx_link.kind  = 1'b0;
        tx_link.wdata = '0;
        case (state)
            PRINT_HDR: begin
                tx_link.wdata = hdr_cnt ? {24'h0, `DCP_CHAR_DASH}
                                        : {24'h0, `DCP_CMD_D};
            end
            PRINT_ADDR: begin
                tx_link.kind  = 1'b1;
                tx_link.wdata = cur_addr;
            end
            PRINT_COLON: begin
                tx_link.wdata = {24'h0, `DCP_CHAR_COLON};
            end
            PRINT_DATA: begin
                tx_link.kind  = 1'b1;
                tx_link.wdata = mem_rdata;
            end
            FINISH: begin
                tx_link.wdata = trl_cnt ? {24'h0, `DCP_CHAR_LF}
                                        : {24'h0, `DCP_CHAR_CR};
            end
            default: begin
                tx_link.wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= INIT;
            rx_req    <= 1'b0;
            tx_req    <= 1'b0;
            hdr_cnt   <= 1'b0;
            trl_cnt   <= 1'b0;
            word_cnt  <= '0;
            last_addr <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            case (state)
                INIT: begin
                    if (start) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    if (rx_link.ack) begin
                        rx_req <= 1'b0;
                        state  <= PRINT_HDR;
                    end else begin
                        rx_req <= 1'b1;
                    end
                end
                PRINT_HDR: begin
                    // "D" then "-"
                    if (tx_link.ack) begin
                        tx_req  <= 1'b0;
                        hdr_cnt <= ~hdr_cnt;
                        if (hdr_cnt) begin
                            state <= PRINT_ADDR;
                        end
                    end else begin
                        tx_req <= 1'b1;
                    end
                end
                PRINT_ADDR: begin
                    if (tx_link.ack) begin
                        tx_req <= 1'b0;
                        state  <= PRINT_COLON;
                    end else begin
                        tx_req <= 1'b1;
                    end
                end
                PRINT_COLON: begin
                    if (tx_link.ack) begin
                        tx_req   <= 1'b0;
                        word_cnt <= '0;
                        state    <= FETCH;
                    end else begin
                        tx_req <= 1'b1;
                    end
                end
                FETCH: begin
                    state <= PRINT_DATA;
                end
                PRINT_DATA: begin
                    if (tx_link.ack) begin
                        tx_req   <= 1'b0;
                        word_cnt <= word_cnt + 1'b1;
                        state    <= (word_cnt == LAST_WORD) ? FINISH : FETCH;
                    end else begin
                        tx_req <= 1'b1;
                    end
                end
                FINISH: begin
                    // CR then LF, finish goes with the LF ack
                    if (tx_link.ack) begin
                        tx_req  <= 1'b0;
                        trl_cnt <= ~trl_cnt;
                        if (trl_cnt) begin
                            last_addr <= cur_addr + 1'b1;
                            finish    <= 1'b1;
                            state     <= INIT;
                        end
                    end else begin
                        tx_req <= 1'b1;
                    end
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // start address, then step once per word after the first
    always_ff @(posedge clk) begin
        if (state == SCAN && rx_link.ack) begin
            cur_addr <= rx_link.empty ? last_addr : rx_link.rdata;
        end else if (state == FETCH && word_cnt != '0) begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

endmodule

// ==== hw/dcp_data_mem.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module dcp_data_mem
    import dcp_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  mem_addr_t waddr,
    input  word_t     wdata,
    input  mem_addr_t raddr,
    output word_t     rdata
);
    word_t mem [`DCP_MEM_DEPTH];

    // load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read for the dump
    assign rdata = mem[raddr];

endmodule

// ==== hw/dcp_top.sv ====
`timescale 1ns/1ps

module dcp_top
    import dcp_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      rx_valid,
    input  byte_t     rx_byte,
    input  logic      tx_ready,
    output logic      tx_valid,
    output byte_t     tx_byte,
    input  logic      mem_we,
    input  mem_addr_t mem_addr,
    input  word_t     mem_wdata,
    output logic      busy
);
    byte_t     sel_mode;
    logic      finish;
    mem_addr_t rd_addr;
    word_t     rd_data;

    dcp_link_if rx_link ();
    dcp_link_if tx_link ();

    // busy for as long as a command is selected
    assign busy = (sel_mode != 8'h00);

    dcp_cmd_decode u_cmd (
        .clk      (clk),
        .rstn     (rstn),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .finish   (finish),
        .sel_mode (sel_mode)
    );

    dcp_rx_scanner u_rx (
        .clk      (clk),
        .rstn     (rstn),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .link     (rx_link.server)
    );

    dcp_tx_printer u_tx (
        .clk      (clk),
        .rstn     (rstn),
        .link     (tx_link.server),
        .tx_ready (tx_ready),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte)
    );

    dcp_dump u_dump (
        .clk       (clk),
        .rstn      (rstn),
        .sel_mode  (sel_mode),
        .rx_link   (rx_link.requester),
        .tx_link   (tx_link.requester),
        .mem_addr  (rd_addr),
        .mem_rdata (rd_data),
        .finish    (finish)
    );

    dcp_data_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // release lands just after a rising edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;
    end
endmodule

// ==== tests/tb_dcp.sv ====
`timescale 1ns/1ps
`include "dcp_consts.svh"

module tb_dcp
    import dcp_pkg::*;
();
    localparam int          CLK_PERIOD  = 20;
    localparam int          LINE_LEN    = 77;
    localparam int          N_DUMPS     = 7;
    localparam int          WORST_STALL = 12;
    localparam int          LINE_WAIT   = LINE_LEN * WORST_STALL + 40;
    localparam logic [31:0] SEED        = 32'hedab_2fc6;
    localparam int          WATCHDOG_NS = 2 * CLK_PERIOD *
        (`DCP_MEM_DEPTH + N_DUMPS * (LINE_LEN * WORST_STALL + 40));

    logic      clk;
    logic      rstn;
    logic      rx_valid;
    byte_t     rx_byte;
    logic      tx_ready;
    logic      tx_valid;
    byte_t     tx_byte;
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    logic      busy;

    // reference model state
    word_t       model_mem [`DCP_MEM_DEPTH];
    word_t       model_last;
    byte_t       exp_bytes [N_DUMPS * LINE_LEN];
    int          exp_total  = 0;
    int          seen_total = 0;
    byte_t       exp_head;
    logic        emit_seen  = 1'b0;
    logic [31:0] lfsr;
    logic        stall_en;

    int mismatch_errs = 0;
    int extra_errs    = 0;
    int busy_errs     = 0;
    int check_errs    = 0;

    tb_clkgen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    dcp_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .tx_ready  (tx_ready),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .busy      (busy)
    );

    assign exp_head = (seen_total < exp_total) ? exp_bytes[seen_total] : 8'h00;

    // outputs settle well before the falling edge
    a_expected: assert property (@(negedge clk) disable iff (!rstn)
        tx_valid |-> (seen_total < exp_total))
    else begin
        extra_errs = extra_errs + 1;
        $display("unexpected byte %h sent beyond the expected line", tx_byte);
    end

    a_byte: assert property (@(negedge clk) disable iff (!rstn)
        (tx_valid && (seen_total < exp_total)) |-> (tx_byte == exp_head))
    else begin
        mismatch_errs = mismatch_errs + 1;
        $display("Mismatch tx_byte: expected %h, actual %h", exp_head, tx_byte);
    end

    always @(negedge clk) begin
        emit_seen <= rstn && tx_valid;
        if (rstn && tx_valid) begin
            assert (busy) else begin
                busy_errs = busy_errs + 1;
                $display("busy was low while a byte was being sent");
            end
        end
    end

    // a byte seen at the falling edge is taken at the next rising edge
    always @(posedge clk) begin
        if (emit_seen) begin
            seen_total <= seen_total + 1;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // advance n cycles and redraw tx_ready when stalling
    task automatic step(input int n);
        word_t b;
        repeat (n) begin
            @(posedge clk);
            #2;
            if (stall_en) begin
                take_bits(1, b);
                tx_ready = b[0];
            end else begin
                tx_ready = 1'b1;
            end
        end
    endtask

    task automatic send_char(input byte_t c);
        rx_valid = 1'b1;
        rx_byte  = c;
        step(1);
        rx_valid = 1'b0;
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            check_errs = check_errs + 1;
            $display("Mismatch %s: expected 0, actual %h", name, value);
        end
    endtask

    // -1 for anything that is not a hex digit
    function automatic int hex_value(input byte_t c);
        if (c >= 8'h30 && c <= 8'h39) begin
            return int'(c) - 48;
        end
        if (c >= 8'h41 && c <= 8'h46) begin
            return int'(c) - 55;
        end
        if (c >= 8'h61 && c <= 8'h66) begin
            return int'(c) - 87;
        end
        return -1;
    endfunction

    function automatic byte_t hex_digit(input logic [3:0] n);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[n];
    endfunction

    task automatic push_byte(input byte_t b);
        exp_bytes[exp_total] = b;
        exp_total            = exp_total + 1;
    endtask

    task automatic push_word(input word_t w);
        for (int i = 7; i >= 0; i--) begin
            push_byte(hex_digit(w[4 * i +: 4]));
        end
    endtask

    // "D-", address, ":", eight words, CR LF
    task automatic build_line(input word_t start);
        mem_addr_t idx;
        push_byte("D");
        push_byte("-");
        push_word(start);
        push_byte(":");
        for (int i = 0; i < `DCP_WORDS_PER_DUMP; i++) begin
            idx = mem_addr_t'(start + word_t'(i));
            push_word(model_mem[idx]);
        end
        push_byte(8'h0D);
        push_byte(8'h0A);
    endtask

    task automatic load_memory();
        word_t w;
        for (int i = 0; i < `DCP_MEM_DEPTH; i++) begin
            take_bits(32, w);
            model_mem[i] = w;
            mem_we       = 1'b1;
            mem_addr     = mem_addr_t'(i);
            mem_wdata    = w;
            step(1);
        end
        mem_we = 1'b0;
    endtask

    task automatic send_noise(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_char(text[i]);
        end
        send_char(8'h0D);
        step(6);
        check_low("busy", busy);
    endtask

    task automatic run_dump(input string text);
        word_t val;
        word_t start;
        logic  got;
        int    nib;
        int    line_start;
        int    wait_cnt;
        val = '0;
        got = 1'b0;
        // only the last eight digits survive the shift
        for (int i = 0; i < text.len(); i++) begin
            nib = hex_value(text[i]);
            if (nib >= 0) begin
                val = {val[27:0], nib[3:0]};
                got = 1'b1;
            end
        end
        start      = got ? val : model_last;
        model_last = start + 32'd8;
        line_start = exp_total;
        build_line(start);

        send_char("D");
        wait_cnt = 0;
        while (!busy && wait_cnt < 8) begin
            step(1);
            wait_cnt = wait_cnt + 1;
        end
        assert (busy) else begin
            check_errs = check_errs + 1;
            $display("busy did not rise after the D command");
        end
        // sequencer needs a few cycles to open the address request
        step(6);
        for (int i = 0; i < text.len(); i++) begin
            send_char(text[i]);
        end
        send_char(8'h0D);

        // a short line runs out the wait and shows up in the length check
        wait_cnt = 0;
        while (seen_total < exp_total && wait_cnt < LINE_WAIT) begin
            step(1);
            wait_cnt = wait_cnt + 1;
        end
        wait_cnt = 0;
        while (busy && wait_cnt < 8) begin
            step(1);
            wait_cnt = wait_cnt + 1;
        end
        assert (!busy) else begin
            check_errs = check_errs + 1;
            $display("busy stayed high after the LF of the line at %h", start);
        end
        step(4);
        assert (seen_total - line_start == LINE_LEN) else begin
            check_errs = check_errs + 1;
            $display("line at %h had %0d bytes instead of %0d",
                     start, seen_total - line_start, LINE_LEN);
        end
    endtask

    initial begin
        int total;
        rx_valid   = 1'b0;
        rx_byte    = 8'h00;
        tx_ready   = 1'b1;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        lfsr       = SEED;
        stall_en   = 1'b0;
        model_last = '0;

        @(posedge rstn);
        step(1);
        check_low("tx_valid", tx_valid);
        check_low("busy", busy);

        load_memory();
        send_noise("x1d-:");

        run_dump("1F");
        run_dump("");
        run_dump("");
        // reads wrap past the top of memory
        run_dump("FC");
        run_dump("");
        send_noise("7e?");

        stall_en = 1'b1;
        run_dump("1f");
        run_dump("9zab-CDef0123");
        stall_en = 1'b0;
        step(4);

        total = mismatch_errs + extra_errs + busy_errs + check_errs;
        $display("errors: %0d (mismatch %0d, extra %0d, busy %0d, other %0d)",
                 total, mismatch_errs, extra_errs, busy_errs, check_errs);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all dumps completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/dcp_pkg.sv
hw/dcp_link_if.sv
hw/dcp_cmd_decode.sv
hw/dcp_rx_scanner.sv
hw/dcp_tx_printer.sv
hw/dcp_dump.sv
hw/dcp_data_mem.sv
hw/dcp_top.sv
tests/tb_clkgen.sv
tests/tb_dcp.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_dcp -f tb.f -o tb_dcp_sim \
    && ./obj_dir/tb_dcp_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
